// File: design/mem_2r1w_pkg.sv
`default_nettype none

package mem_2r1w_pkg;

  localparam int WIDTH = 8;

  // bank index lives in the low address bits
  localparam int BANK_BITS = 2;
  localparam int NUM_BANKS = 1 << BANK_BITS;
  localparam int ROW_BITS = 4;
  localparam int NUM_ROWS = 1 << ROW_BITS;
  localparam int ADDR_BITS = ROW_BITS + BANK_BITS;

  localparam int NUM_RPORTS = 2;

  typedef struct packed {
    logic [ROW_BITS-1:0]  row;
    logic [BANK_BITS-1:0] bank;
  } addr_fields_t;

  // flat word or row/bank pair
  typedef union packed {
    logic [ADDR_BITS-1:0] flat;
    addr_fields_t         f;
  } addr_u;

endpackage

`default_nettype wire

// File: design/bank_sram.sv
`timescale 1ns/1ps
`default_nettype none

module bank_sram #(
  parameter int SRAM_DELAY = 2
) (
  input  logic                              clk,
  input  logic                              arst_n,
  input  logic                              rd_en,
  input  logic [mem_2r1w_pkg::ROW_BITS-1:0] rd_row,
  input  logic                              wr_en,
  input  logic [mem_2r1w_pkg::ROW_BITS-1:0] wr_row,
  input  logic [mem_2r1w_pkg::WIDTH-1:0]    wr_data,
  output logic [mem_2r1w_pkg::WIDTH-1:0]    rd_data
);

  logic [mem_2r1w_pkg::WIDTH-1:0] mem [mem_2r1w_pkg::NUM_ROWS];
  logic [mem_2r1w_pkg::WIDTH-1:0] rd_pipe [SRAM_DELAY];

  // all zero after reset keeps the parity bank consistent
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      for (int r = 0; r < mem_2r1w_pkg::NUM_ROWS; r++) begin
        mem[r] <= '0;
      end
    end else if (wr_en) begin
      mem[wr_row] <= wr_data;
    end
  end

  // read sees the array before a same-cycle write
  always_ff @(posedge clk) begin
    if (rd_en) begin
      rd_pipe[0] <= mem[rd_row];
    end
    for (int i = 1; i < SRAM_DELAY; i++) begin
      rd_pipe[i] <= rd_pipe[i-1];
    end
  end

  assign rd_data = rd_pipe[SRAM_DELAY-1];

endmodule

`default_nettype wire

// File: design/bank_arbiter.sv
`timescale 1ns/1ps
`default_nettype none

module bank_arbiter (
  input  logic                                  write,
  input  logic [mem_2r1w_pkg::ADDR_BITS-1:0]    wr_adr,
  input  logic [mem_2r1w_pkg::NUM_RPORTS-1:0]   read,
  input  logic [mem_2r1w_pkg::ADDR_BITS-1:0]    rd_adr_0,
  input  logic [mem_2r1w_pkg::ADDR_BITS-1:0]    rd_adr_1,
  output logic [mem_2r1w_pkg::NUM_BANKS-1:0]    bank_rd_en,
  output logic [mem_2r1w_pkg::NUM_BANKS*mem_2r1w_pkg::ROW_BITS-1:0] bank_rd_row,
  output logic [mem_2r1w_pkg::NUM_BANKS-1:0]    bank_wr_en,
  output logic                                  xor_rd_en,
  output logic [mem_2r1w_pkg::ROW_BITS-1:0]     xor_rd_row,
  output logic                                  cflt
);

  localparam int RB = mem_2r1w_pkg::ROW_BITS;

  mem_2r1w_pkg::addr_u wr_a;
  mem_2r1w_pkg::addr_u rd_a0;
  mem_2r1w_pkg::addr_u rd_a1;

  assign wr_a.flat  = wr_adr;
  assign rd_a0.flat = rd_adr_0;
  assign rd_a1.flat = rd_adr_1;

  // port 1 loses when both ports hit one bank
  assign cflt = read[0] && read[1] && (rd_a0.f.bank == rd_a1.f.bank);

  always_comb begin
    bank_rd_en  = '0;
    bank_rd_row = '0;
    bank_wr_en  = '0;
    xor_rd_en   = 1'b0;
    xor_rd_row  = '0;
    if (write) begin
      // old data and old parity for the read-modify-write
      bank_rd_en[wr_a.f.bank]               = 1'b1;
      bank_rd_row[wr_a.f.bank*RB +: RB]     = wr_a.f.row;
      bank_wr_en[wr_a.f.bank]               = 1'b1;
      xor_rd_en                             = 1'b1;
      xor_rd_row                            = wr_a.f.row;
    end else begin
      for (int b = 0; b < mem_2r1w_pkg::NUM_BANKS; b++) begin
        if (read[0] && (rd_a0.f.bank == b)) begin
          bank_rd_en[b]           = 1'b1;
          bank_rd_row[b*RB +: RB] = rd_a0.f.row;
        end else if (cflt || (read[1] && (rd_a1.f.bank == b))) begin
          // on conflict every other bank feeds the rebuild
          bank_rd_en[b]           = 1'b1;
          bank_rd_row[b*RB +: RB] = rd_a1.f.row;
        end
      end
      if (cflt) begin
        xor_rd_en  = 1'b1;
        xor_rd_row = rd_a1.f.row;
      end
    end
  end

endmodule

`default_nettype wire

// File: design/xor_update.sv
`timescale 1ns/1ps
`default_nettype none

module xor_update #(
  parameter int SRAM_DELAY = 2
) (
  input  logic                               clk,
  input  logic                               arst_n,
  input  logic                               write,
  input  logic [mem_2r1w_pkg::ADDR_BITS-1:0] wr_adr,
  input  logic [mem_2r1w_pkg::WIDTH-1:0]     din,
  input  logic                               xor_rd_en,
  input  logic [mem_2r1w_pkg::ROW_BITS-1:0]  xor_rd_row,
  input  logic [mem_2r1w_pkg::NUM_BANKS*mem_2r1w_pkg::WIDTH-1:0] bank_rd_data,
  output logic [mem_2r1w_pkg::WIDTH-1:0]     xor_data
);

  localparam int W = mem_2r1w_pkg::WIDTH;
  localparam int LAST = SRAM_DELAY - 1;

  mem_2r1w_pkg::addr_u wr_a;

  logic [SRAM_DELAY-1:0]               pend_vld;
  logic [mem_2r1w_pkg::ROW_BITS-1:0]   pend_row [SRAM_DELAY];
  logic [mem_2r1w_pkg::BANK_BITS-1:0]  pend_bank [SRAM_DELAY];
  logic [W-1:0]                        pend_din [SRAM_DELAY];
  logic [mem_2r1w_pkg::ROW_BITS-1:0]   xrow_pipe [SRAM_DELAY];
  logic [SRAM_DELAY-1:0]               hist_vld;
  logic [mem_2r1w_pkg::ROW_BITS-1:0]   hist_row [SRAM_DELAY];
  logic [W-1:0]                        hist_val [SRAM_DELAY];
  logic [W-1:0]                        xb_dout;
  logic [W-1:0]                        old_data;
  logic                                cmt_vld;
  logic [mem_2r1w_pkg::ROW_BITS-1:0]   cmt_row;
  logic [W-1:0]                        cmt_val;

  assign wr_a.flat = wr_adr;

  bank_sram #(
    .SRAM_DELAY (SRAM_DELAY)
  ) u_xor_bank (
    .clk     (clk),
    .arst_n  (arst_n),
    .rd_en   (xor_rd_en),
    .rd_row  (xor_rd_row),
    .wr_en   (cmt_vld),
    .wr_row  (cmt_row),
    .wr_data (cmt_val),
    .rd_data (xb_dout)
  );

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      pend_vld <= '0;
      hist_vld <= '0;
    end else begin
      pend_vld[0] <= write;
      hist_vld[0] <= cmt_vld;
      for (int i = 1; i < SRAM_DELAY; i++) begin
        pend_vld[i] <= pend_vld[i-1];
        hist_vld[i] <= hist_vld[i-1];
      end
    end
  end

  always_ff @(posedge clk) begin
    pend_row[0]  <= wr_a.f.row;
    pend_bank[0] <= wr_a.f.bank;
    pend_din[0]  <= din;
    xrow_pipe[0] <= xor_rd_row;
    hist_row[0]  <= cmt_row;
    hist_val[0]  <= cmt_val;
    for (int i = 1; i < SRAM_DELAY; i++) begin
      pend_row[i]  <= pend_row[i-1];
      pend_bank[i] <= pend_bank[i-1];
      pend_din[i]  <= pend_din[i-1];
      xrow_pipe[i] <= xrow_pipe[i-1];
      hist_row[i]  <= hist_row[i-1];
      hist_val[i]  <= hist_val[i-1];
    end
  end

  // commits made while the parity read was in flight, newest wins
  always_comb begin
    xor_data = xb_dout;
    for (int j = LAST; j >= 0; j--) begin
      if (hist_vld[j] && (hist_row[j] == xrow_pipe[LAST])) begin
        xor_data = hist_val[j];
      end
    end
  end

  assign old_data = bank_rd_data[pend_bank[LAST]*W +: W];
  assign cmt_vld  = pend_vld[LAST];
  assign cmt_row  = pend_row[LAST];
  assign cmt_val  = xor_data ^ old_data ^ pend_din[LAST];

endmodule

`default_nettype wire

// File: design/read_reconstruct.sv
`timescale 1ns/1ps
`default_nettype none

module read_reconstruct #(
  parameter int SRAM_DELAY = 2
) (
  input  logic                                clk,
  input  logic                                arst_n,
  input  logic [mem_2r1w_pkg::NUM_RPORTS-1:0] read,
  input  logic [mem_2r1w_pkg::ADDR_BITS-1:0]  rd_adr_0,
  input  logic [mem_2r1w_pkg::ADDR_BITS-1:0]  rd_adr_1,
  input  logic                                cflt,
  input  logic [mem_2r1w_pkg::NUM_BANKS*mem_2r1w_pkg::WIDTH-1:0] bank_rd_data,
  input  logic [mem_2r1w_pkg::WIDTH-1:0]      xor_data,
  output logic [mem_2r1w_pkg::NUM_RPORTS-1:0] rd_vld,
  output logic [mem_2r1w_pkg::WIDTH-1:0]      rd_dout_0,
  output logic [mem_2r1w_pkg::WIDTH-1:0]      rd_dout_1
);

  localparam int W = mem_2r1w_pkg::WIDTH;
  localparam int LAST = SRAM_DELAY - 1;

  mem_2r1w_pkg::addr_u rd_a0;
  mem_2r1w_pkg::addr_u rd_a1;

  logic [mem_2r1w_pkg::NUM_RPORTS-1:0] vld_pipe [SRAM_DELAY];
  logic [SRAM_DELAY-1:0]               cflt_pipe;
  logic [mem_2r1w_pkg::BANK_BITS-1:0]  bank0_pipe [SRAM_DELAY];
  logic [mem_2r1w_pkg::BANK_BITS-1:0]  bank1_pipe [SRAM_DELAY];
  logic [W-1:0]                        rebuilt;

  assign rd_a0.flat = rd_adr_0;
  assign rd_a1.flat = rd_adr_1;

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      for (int i = 0; i < SRAM_DELAY; i++) begin
        vld_pipe[i] <= '0;
      end
      cflt_pipe <= '0;
    end else begin
      vld_pipe[0]  <= read;
      cflt_pipe[0] <= cflt;
      for (int i = 1; i < SRAM_DELAY; i++) begin
        vld_pipe[i]  <= vld_pipe[i-1];
        cflt_pipe[i] <= cflt_pipe[i-1];
      end
    end
  end

  always_ff @(posedge clk) begin
    bank0_pipe[0] <= rd_a0.f.bank;
    bank1_pipe[0] <= rd_a1.f.bank;
    for (int i = 1; i < SRAM_DELAY; i++) begin
      bank0_pipe[i] <= bank0_pipe[i-1];
      bank1_pipe[i] <= bank1_pipe[i-1];
    end
  end

  // parity xor all banks but the blocked one
  always_comb begin
    rebuilt = xor_data;
    for (int b = 0; b < mem_2r1w_pkg::NUM_BANKS; b++) begin
      if (bank1_pipe[LAST] != b) begin
        rebuilt = rebuilt ^ bank_rd_data[b*W +: W];
      end
    end
  end

  assign rd_vld    = vld_pipe[LAST];
  assign rd_dout_0 = bank_rd_data[bank0_pipe[LAST]*W +: W];
  assign rd_dout_1 = cflt_pipe[LAST] ? rebuilt : bank_rd_data[bank1_pipe[LAST]*W +: W];

endmodule

`default_nettype wire

// File: design/mem_2r1w_top.sv
`timescale 1ns/1ps
`default_nettype none

module mem_2r1w_top #(
  parameter int SRAM_DELAY = 2
) (
  input  logic                                clk,
  input  logic                                arst_n,
  input  logic                                write,
  input  logic [mem_2r1w_pkg::ADDR_BITS-1:0]  wr_adr,
  input  logic [mem_2r1w_pkg::WIDTH-1:0]      din,
  input  logic [mem_2r1w_pkg::NUM_RPORTS-1:0] read,
  input  logic [mem_2r1w_pkg::ADDR_BITS-1:0]  rd_adr_0,
  input  logic [mem_2r1w_pkg::ADDR_BITS-1:0]  rd_adr_1,
  output logic [mem_2r1w_pkg::NUM_RPORTS-1:0] rd_vld,
  output logic [mem_2r1w_pkg::WIDTH-1:0]      rd_dout_0,
  output logic [mem_2r1w_pkg::WIDTH-1:0]      rd_dout_1
);

  localparam int W  = mem_2r1w_pkg::WIDTH;
  localparam int RB = mem_2r1w_pkg::ROW_BITS;

  mem_2r1w_pkg::addr_u wr_a;

  logic [mem_2r1w_pkg::NUM_BANKS-1:0]    bank_rd_en;
  logic [mem_2r1w_pkg::NUM_BANKS*RB-1:0] bank_rd_row;
  logic [mem_2r1w_pkg::NUM_BANKS-1:0]    bank_wr_en;
  logic [mem_2r1w_pkg::NUM_BANKS*W-1:0]  bank_rd_data;
  logic                                  xor_rd_en;
  logic [RB-1:0]                         xor_rd_row;
  logic [W-1:0]                          xor_data;
  logic                                  cflt;

  assign wr_a.flat = wr_adr;

  bank_arbiter u_bank_arbiter (
    .write       (write),
    .wr_adr      (wr_adr),
    .read        (read),
    .rd_adr_0    (rd_adr_0),
    .rd_adr_1    (rd_adr_1),
    .bank_rd_en  (bank_rd_en),
    .bank_rd_row (bank_rd_row),
    .bank_wr_en  (bank_wr_en),
    .xor_rd_en   (xor_rd_en),
    .xor_rd_row  (xor_rd_row),
    .cflt        (cflt)
  );

  // data banks, write path straight from the ports
  for (genvar g = 0; g < mem_2r1w_pkg::NUM_BANKS; g++) begin : g_bank
    bank_sram #(
      .SRAM_DELAY (SRAM_DELAY)
    ) u_bank_sram (
      .clk     (clk),
      .arst_n  (arst_n),
      .rd_en   (bank_rd_en[g]),
      .rd_row  (bank_rd_row[g*RB +: RB]),
      .wr_en   (bank_wr_en[g]),
      .wr_row  (wr_a.f.row),
      .wr_data (din),
      .rd_data (bank_rd_data[g*W +: W])
    );
  end

  xor_update #(
    .SRAM_DELAY (SRAM_DELAY)
  ) u_xor_update (
    .clk          (clk),
    .arst_n       (arst_n),
    .write        (write),
    .wr_adr       (wr_adr),
    .din          (din),
    .xor_rd_en    (xor_rd_en),
    .xor_rd_row   (xor_rd_row),
    .bank_rd_data (bank_rd_data),
    .xor_data     (xor_data)
  );

  read_reconstruct #(
    .SRAM_DELAY (SRAM_DELAY)
  ) u_read_reconstruct (
    .clk          (clk),
    .arst_n       (arst_n),
    .read         (read),
    .rd_adr_0     (rd_adr_0),
    .rd_adr_1     (rd_adr_1),
    .cflt         (cflt),
    .bank_rd_data (bank_rd_data),
    .xor_data     (xor_data),
    .rd_vld       (rd_vld),
    .rd_dout_0    (rd_dout_0),
    .rd_dout_1    (rd_dout_1)
  );

endmodule

`default_nettype wire

// File: tb/tb_mem_2r1w.sv
`timescale 1ns/1ps
`default_nettype none

module tb_mem_2r1w;

  localparam int SRAM_DELAY = 2;
  localparam int CLK_PERIOD = 40;
  localparam int RST_CYCLES = 5;
  localparam int TEST_CYCLES = 2000;
  localparam int WATCHDOG_CYCLES = RST_CYCLES + TEST_CYCLES + 20;
  localparam int W = mem_2r1w_pkg::WIDTH;
  localparam int AB = mem_2r1w_pkg::ADDR_BITS;
  localparam int NB = mem_2r1w_pkg::NUM_BANKS;
  localparam int NR = mem_2r1w_pkg::NUM_ROWS;
  localparam int NA = NB * NR;

  logic          clk;
  logic          arst_n;
  logic          write;
  logic [AB-1:0] wr_adr;
  logic [W-1:0]  din;
  logic [1:0]    read;
  logic [AB-1:0] rd_adr_0;
  logic [AB-1:0] rd_adr_1;
  logic [1:0]    rd_vld;
  logic [W-1:0]  rd_dout_0;
  logic [W-1:0]  rd_dout_1;

  logic [W-1:0] model [NB][NR];
  logic [W-1:0] exp_q0 [$];
  logic [W-1:0] exp_q1 [$];
  // read bits issued in the last SRAM_DELAY cycles, oldest at the end
  logic [1:0]   issued [SRAM_DELAY];
  integer       seed;
  int           data_errs;
  int           hs_errs;
  int           checked;
  int           cycles;

  mem_2r1w_top #(
    .SRAM_DELAY (SRAM_DELAY)
  ) u_mem_2r1w_top (
    .clk       (clk),
    .arst_n    (arst_n),
    .write     (write),
    .wr_adr    (wr_adr),
    .din       (din),
    .read      (read),
    .rd_adr_0  (rd_adr_0),
    .rd_adr_1  (rd_adr_1),
    .rd_vld    (rd_vld),
    .rd_dout_0 (rd_dout_0),
    .rd_dout_1 (rd_dout_1)
  );

  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  // bank in the low address bits, row above
  function automatic int bank_of(int a);
    return a % NB;
  endfunction

  function automatic int row_of(int a);
    return a / NB;
  endfunction

  function automatic logic [AB-1:0] make_addr(int b, int r);
    return AB'(r * NB + b);
  endfunction

  function automatic logic [31:0] rand_word();
    return $random(seed);
  endfunction

  task automatic check_port(int p, logic exp_vld, logic vld, logic [W-1:0] got);
    logic [W-1:0] exp_word;
    logic         have;
    have = 1'b0;
    exp_word = '0;
    assert (!(exp_vld && (vld !== 1'b1))) else begin
      $display("port %0d gave no rd_vld %0d cycles after its read", p, SRAM_DELAY);
      hs_errs++;
    end
    if (vld === 1'b1) begin
      assert (exp_vld) else begin
        $display("port %0d raised rd_vld with no read %0d cycles before", p, SRAM_DELAY);
        hs_errs++;
      end
      if (p == 0) begin
        have = exp_q0.size() > 0;
        if (have) exp_word = exp_q0.pop_front();
      end else begin
        have = exp_q1.size() > 0;
        if (have) exp_word = exp_q1.pop_front();
      end
      assert (have) else begin
        $display("port %0d raised rd_vld while no read was waiting", p);
        hs_errs++;
      end
      if (have) begin
        checked++;
        assert (got === exp_word) else begin
          $display("CHECK FAILED: rd_dout_%0d = 0x%02h, expected 0x%02h", p, got, exp_word);
          data_errs++;
        end
      end
    end
  endtask

  // one clock, outputs checked before new inputs go out
  task automatic advance();
    @(negedge clk);
    check_port(0, issued[SRAM_DELAY-1][0], rd_vld[0], rd_dout_0);
    check_port(1, issued[SRAM_DELAY-1][1], rd_vld[1], rd_dout_1);
    for (int i = SRAM_DELAY - 1; i > 0; i--) begin
      issued[i] = issued[i-1];
    end
    issued[0] = 2'b00;
    write = 1'b0;
    read = 2'b00;
    cycles++;
  endtask

  task automatic do_idle();
    advance();
  endtask

  task automatic do_write(logic [AB-1:0] a, logic [W-1:0] d);
    advance();
    write = 1'b1;
    wr_adr = a;
    din = d;
    model[bank_of(a)][row_of(a)] = d;
  endtask

  task automatic do_read(logic [1:0] en, logic [AB-1:0] a0, logic [AB-1:0] a1);
    advance();
    read = en;
    rd_adr_0 = a0;
    rd_adr_1 = a1;
    issued[0] = en;
    if (en[0]) exp_q0.push_back(model[bank_of(a0)][row_of(a0)]);
    if (en[1]) exp_q1.push_back(model[bank_of(a1)][row_of(a1)]);
  endtask

  initial begin
    logic [31:0] x;
    int          a0;
    int          a1;
    int          b;
    int          r;
    int          len;
    seed = 61;
    data_errs = 0;
    hs_errs = 0;
    checked = 0;
    cycles = 0;
    arst_n = 1'b0;
    write = 1'b0;
    wr_adr = '0;
    din = '0;
    read = 2'b00;
    rd_adr_0 = '0;
    rd_adr_1 = '0;
    for (int i = 0; i < SRAM_DELAY; i++) begin
      issued[i] = 2'b00;
    end
    for (int i = 0; i < NB; i++) begin
      for (int j = 0; j < NR; j++) begin
        model[i][j] = '0;
      end
    end
    repeat (RST_CYCLES) @(negedge clk);
    arst_n = 1'b1;

    // quiet outputs, then reads of untouched memory
    repeat (4) do_idle();
    for (int a = 0; a < NA; a++) begin
      do_read(2'b11, AB'(a), AB'(NA - 1 - a));
    end
    for (int a = 0; a < NA; a++) begin
      do_write(AB'(a), W'(rand_word()));
    end

    // back-to-back reads, one port at a time
    for (int a = 0; a < NA; a++) begin
      do_read(2'b01, AB'(a), '0);
    end
    for (int a = 0; a < NA; a++) begin
      do_read(2'b10, '0, AB'(NA - 1 - a));
    end

    // two ports on different banks
    for (int k = 0; k < 100; k++) begin
      x = rand_word();
      a0 = x % NA;
      b = (bank_of(a0) + 1 + (x >> 8) % (NB - 1)) % NB;
      do_read(2'b11, AB'(a0), make_addr(b, (x >> 16) % NR));
    end

    // same bank, different rows, every bank in turn
    for (int k = 0; k < 8; k++) begin
      for (int i = 0; i < NB; i++) begin
        x = rand_word();
        r = x % NR;
        do_read(2'b11, make_addr(i, r), make_addr(i, (r + 1 + (x >> 8) % (NR - 1)) % NR));
      end
    end

    // write bursts on one row, rebuilt right after
    for (int k = 0; k < 20; k++) begin
      x = rand_word();
      r = x % NR;
      len = 1 + (x >> 8) % NB;
      b = (x >> 12) % NB;
      for (int i = 0; i < len; i++) begin
        do_write(make_addr((b + i) % NB, r), W'(rand_word()));
      end
      for (int i = 0; i < NB; i++) begin
        x = rand_word();
        do_read(2'b11, make_addr(i, x % NR), make_addr(i, r));
      end
    end

    // both ports on one address
    for (int k = 0; k < 50; k++) begin
      x = rand_word();
      do_read(2'b11, AB'(x % NA), AB'(x % NA));
    end

    // random mix, half of it squeezed onto two rows
    for (int k = 0; k < 1200; k++) begin
      x = rand_word();
      a0 = x[4] ? (x >> 8) % (2 * NB) : (x >> 8) % NA;
      a1 = x[4] ? (x >> 16) % (2 * NB) : (x >> 16) % NA;
      case (x[2:0])
        3'd0: do_idle();
        3'd1, 3'd2: do_write(AB'(a0), W'(x >> 24));
        3'd3: do_read(x[3] ? 2'b10 : 2'b01, AB'(a0), AB'(a1));
        default: do_read(2'b11, AB'(a0), AB'(a1));
      endcase
    end

    repeat (SRAM_DELAY + 2) do_idle();
    assert (exp_q0.size() == 0 && exp_q1.size() == 0) else begin
      $display("reads never answered: port 0 %0d, port 1 %0d", exp_q0.size(), exp_q1.size());
      hs_errs++;
    end
    $display("errors: data %0d, handshake %0d; reads checked %0d in %0d cycles",
             data_errs, hs_errs, checked, cycles);
    if (data_errs + hs_errs == 0) begin
      $display(">>> PASS");
    end else begin
      $display(">>> FAIL");
    end
    $finish;
  end

  initial begin
    #(WATCHDOG_CYCLES * CLK_PERIOD);
    $display("watchdog timeout after %0d cycles, test did not finish", WATCHDOG_CYCLES);
    $display("errors: data %0d, handshake %0d; reads checked %0d", data_errs, hs_errs, checked);
    $display(">>> FAIL");
    $finish;
  end

endmodule

`default_nettype wire

// File: flist.f
design/mem_2r1w_pkg.sv
design/bank_sram.sv
design/bank_arbiter.sv
design/xor_update.sv
design/read_reconstruct.sv
design/mem_2r1w_top.sv
tb/tb_mem_2r1w.sv

// File: Bender.yml
package:
  name: mem_2r1w

sources:
  - design/mem_2r1w_pkg.sv
  - design/bank_sram.sv
  - design/bank_arbiter.sv
  - design/xor_update.sv
  - design/read_reconstruct.sv
  - design/mem_2r1w_top.sv
  - target: test
    files:
      - tb/tb_mem_2r1w.sv
